// ==== include/keypad_defines.svh ====
`ifndef KEYPAD_DEFINES_SVH
`define KEYPAD_DEFINES_SVH

//////////////////////////////
// Timing dividers
//////////////////////////////

// Clocks per row step of the scanner
`define KP_SCAN_DIV 4

// Clocks between debounce samples
// Keep at or above 4 * KP_SCAN_DIV * 4 so a full scan lands between samples
`define KP_DEBOUNCE_TICKS 64

//////////////////////////////
// Event queue
//////////////////////////////

// Entries in the event FIFO, power of two
`define KP_FIFO_DEPTH 8

//////////////////////////////
// Register map (word addresses)
//////////////////////////////

`define KP_ADDR_STATUS 2'd0
`define KP_ADDR_DATA 2'd1
`define KP_ADDR_KEYS 2'd2
`define KP_ADDR_CTRL 2'd3

`endif

// ==== design/keypad_pkg.sv ====
package keypad_pkg;

    // One bit per key, 1 = pressed
    // Bit index is row * 4 + column
    typedef logic [15:0] key_map_t;

    // Queued key event
    typedef struct packed {
        logic       chord;  // Other keys held at press time
        logic [3:0] code;   // row * 4 + column
    } key_event_t;

    // STATUS register layout
    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic [3:0]  count;
        logic [1:0]  rsvd_lo;
        logic        overflow;
        logic        empty;
    } status_t;

    // CTRL register layout
    typedef struct packed {
        logic irq_en;
        logic scan_en;
    } ctrl_t;

endpackage

// ==== design/keypad_scanner.sv ====
`include "keypad_defines.svh"

module keypad_scanner (
    input  logic                clk,
    input  logic                rstn,
    input  logic                enable,
    input  logic [3:0]          col,
    output logic [3:0]          row,
    output keypad_pkg::key_map_t raw_map
);

    localparam int DIV   = `KP_SCAN_DIV;
    localparam int CNT_W = $clog2(DIV + 1);

    logic [CNT_W-1:0] div_cnt;
    logic             step;
    logic [1:0]       row_idx;

    // Last clock of a row step
    assign step = (div_cnt == CNT_W'(DIV - 1));

    // Active row back to an index
    always_comb begin
        case (row)
            4'b1101: row_idx = 2'd1;
            4'b1011: row_idx = 2'd2;
            4'b0111: row_idx = 2'd3;
            default: row_idx = 2'd0;
        endcase
    end

    //////////////////////////////
    // Row rotation and sampling
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row     <= 4'b1111;
            div_cnt <= '0;
            raw_map <= '0;
        end else if (!enable) begin
            // Rows released, counter and map frozen
            row <= 4'b1111;
        end else if (row == 4'b1111) begin
            // Start scan on row 0
            row     <= 4'b1110;
            div_cnt <= '0;
        end else if (step) begin
            // Columns are active low
            raw_map[row_idx*4 +: 4] <= ~col;
            row     <= {row[2:0], row[3]};
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Once running, exactly one row pulled low
    a_one_row: assert property (@(posedge clk) disable iff (!rstn)
        enable && $past(enable) |-> $onehot(~row));

endmodule

// ==== design/key_debouncer.sv ====
`include "keypad_defines.svh"

module key_debouncer (
    input  logic                 clk,
    input  logic                 rstn,
    input  keypad_pkg::key_map_t raw_map,
    output keypad_pkg::key_map_t key_level,
    output keypad_pkg::key_map_t press_mask
);

    localparam int TICKS = `KP_DEBOUNCE_TICKS;
    localparam int CNT_W = $clog2(TICKS + 1);

    logic [CNT_W-1:0]     smp_cnt;
    logic                 sample;
    keypad_pkg::key_map_t snap0;
    keypad_pkg::key_map_t snap1;

    //////////////////////////////
    // Sample instants
    //////////////////////////////

    assign sample = (smp_cnt == CNT_W'(TICKS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            smp_cnt <= '0;
        end else if (sample) begin
            smp_cnt <= '0;
        end else begin
            smp_cnt <= smp_cnt + 1'b1;
        end
    end

    // History with snap0 newest
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            snap0      <= '0;
            snap1      <= '0;
            press_mask <= '0;
        end else begin
            if (sample) begin
                snap0 <= raw_map;
                snap1 <= snap0;
            end
            // Pressed, pressed, released with raw_map as the newest sample
            press_mask <= sample ? (raw_map & snap0 & ~snap1) : '0;
        end
    end

    // Stable when two samples agree on pressed
    assign key_level = snap0 & snap1;

    // A strobed key is stable now and was not stable before
    a_press_new_level: assert property (@(posedge clk) disable iff (!rstn)
        (press_mask != '0) |-> ((press_mask & ~key_level) == '0)
            && ((press_mask & $past(key_level)) == '0));

endmodule

// ==== design/key_event_fifo.sv ====
`include "keypad_defines.svh"

module key_event_fifo #(
    parameter type payload_t = keypad_pkg::key_event_t
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     push,
    input  logic     pop,
    input  payload_t wr_data,
    output payload_t rd_data,
    output logic     empty,
    output logic     full,
    output logic [3:0] count
);

    localparam int DEPTH = `KP_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_push;
    logic          do_pop;

    // Full FIFO still takes a push paired with a pop
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    assign empty   = (count == 4'd0);
    assign full    = (count == 4'(DEPTH));
    // Head visible without popping
    assign rd_data = mem[rd_ptr];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + 4'(do_push) - 4'(do_pop);
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> !empty);
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        push && full |-> pop);

endmodule

// ==== design/keypad_wb_ctrl.sv ====
`include "keypad_defines.svh"

module keypad_wb_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    // Wishbone classic slave
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [1:0]              adr,
    input  logic [31:0]             dat_w,
    output logic [31:0]             dat_r,
    output logic                    ack,
    output logic                    irq,
    output logic                    scan_en,
    // From debouncer
    input  keypad_pkg::key_map_t    key_level,
    input  keypad_pkg::key_map_t    press_mask,
    // Event FIFO
    output logic                    push,
    output keypad_pkg::key_event_t  wr_data,
    output logic                    pop,
    input  keypad_pkg::key_event_t  rd_data,
    input  logic                    empty,
    input  logic                    full,
    input  logic [3:0]              count
);

    keypad_pkg::ctrl_t    ctrl_q;
    keypad_pkg::status_t  status_w;
    keypad_pkg::key_map_t pending;
    logic                 chord_q;
    logic [3:0]           sel_idx;
    logic                 have_evt;
    logic                 fifo_ok;
    logic                 bus_wr;
    logic                 overflow;

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    // One-cycle ack that never repeats back to back
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
    end

    assign bus_wr = ack && cyc && stb && we;
    // Pop in the ack cycle of a DATA read
    assign pop    = ack && cyc && stb && !we && (adr == `KP_ADDR_DATA) && !empty;

    always_comb begin
        status_w          = '0;
        status_w.empty    = empty;
        status_w.overflow = overflow;
        status_w.count    = count;
    end

    // Read mux sampled by the master while ack is high
    always_comb begin
        case (adr)
            `KP_ADDR_STATUS: dat_r = status_w;
            `KP_ADDR_DATA:   dat_r = empty ? 32'd0 : {23'd0, 1'b1, 3'd0, rd_data};
            `KP_ADDR_KEYS:   dat_r = {16'd0, key_level};
            default:         dat_r = {30'd0, ctrl_q};
        endcase
    end

    //////////////////////////////
    // Press to event encoder
    //////////////////////////////

    // Lowest pending index wins
    always_comb begin
        sel_idx = 4'd0;
        for (int i = 15; i >= 0; i--) begin
            if (pending[i]) sel_idx = 4'(i);
        end
    end

    assign have_evt = |pending;
    assign fifo_ok  = !full || pop;
    assign push     = have_evt && fifo_ok;
    assign wr_data  = '{chord: chord_q, code: sel_idx};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= '0;
            chord_q <= 1'b0;
        end else begin
            // Selected bit leaves whether pushed or dropped
            pending <= (pending & ~(16'd1 << sel_idx)) | press_mask;
            if (|press_mask) begin
                chord_q <= ($countones(key_level) > 1);
            end
        end
    end

    //////////////////////////////
    // Registers and interrupt
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_q   <= '0;
            overflow <= 1'b0;
            irq      <= 1'b0;
        end else begin
            if (bus_wr && (adr == `KP_ADDR_CTRL)) begin
                ctrl_q <= dat_w[1:0];
            end
            // Drop beats clear in the same cycle
            if (have_evt && !fifo_ok) begin
                overflow <= 1'b1;
            end else if (bus_wr && (adr == `KP_ADDR_STATUS) && dat_w[1]) begin
                overflow <= 1'b0;
            end
            irq <= ctrl_q.irq_en && !empty;
        end
    end

    assign scan_en = ctrl_q.scan_en;

    // Master keeps its request up through the ack cycle
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        ack |-> cyc && stb);

endmodule

// ==== design/keypad_top.sv ====
module keypad_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    output logic        irq,
    input  logic [3:0]  col,
    output logic [3:0]  row
);

    logic                   scan_en;
    keypad_pkg::key_map_t   raw_map;
    keypad_pkg::key_map_t   key_level;
    keypad_pkg::key_map_t   press_mask;
    logic                   push;
    logic                   pop;
    keypad_pkg::key_event_t wr_data;
    keypad_pkg::key_event_t rd_data;
    logic                   empty;
    logic                   full;
    logic [3:0]             count;

    //////////////////////////////
    // Scan and debounce
    //////////////////////////////

    keypad_scanner scanner_i (
        .clk     (clk),
        .rstn    (rstn),
        .enable  (scan_en),
        .col     (col),
        .row     (row),
        .raw_map (raw_map)
    );

    key_debouncer debouncer_i (
        .clk        (clk),
        .rstn       (rstn),
        .raw_map    (raw_map),
        .key_level  (key_level),
        .press_mask (press_mask)
    );

    //////////////////////////////
    // Event queue and bus
    //////////////////////////////

    key_event_fifo #(
        .payload_t (keypad_pkg::key_event_t)
    ) fifo_i (
        .clk     (clk),
        .rstn    (rstn),
        .push    (push),
        .pop     (pop),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .empty   (empty),
        .full    (full),
        .count   (count)
    );

    keypad_wb_ctrl ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .irq        (irq),
        .scan_en    (scan_en),
        .key_level  (key_level),
        .press_mask (press_mask),
        .push       (push),
        .wr_data    (wr_data),
        .pop        (pop),
        .rd_data    (rd_data),
        .empty      (empty),
        .full       (full),
        .count      (count)
    );

endmodule

// ==== verification/keypad_matrix_model.sv ====
module keypad_matrix_model (
    input  logic [3:0]  row,
    input  logic [15:0] pressed,
    output logic [3:0]  col
);

    //////////////////////////////
    // Switch matrix
    //////////////////////////////

    // Columns idle high through pull-ups
    // A pressed key shorts its column to its row
    always_comb begin
        col = 4'hF;
        for (int r = 0; r < 4; r++) begin
            // Only a driven row can pull a column low
            if (!row[r]) begin
                for (int c = 0; c < 4; c++) begin
                    if (pressed[r*4 + c]) begin
                        col[c] = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== verification/tb_keypad_top.sv ====
`include "keypad_defines.svh"

module tb_keypad_top;

    localparam int SEED     = 56369;
    localparam int PERIOD   = 20;
    localparam int DLY      = 2;
    localparam int TICKS    = `KP_DEBOUNCE_TICKS;
    localparam int DEPTH    = `KP_FIFO_DEPTH;
    localparam int HOLD     = 6;
    localparam int N_SINGLE = 6;
    localparam int N_MULTI  = 6;
    localparam int N_GLITCH = 4;
    localparam int MAX_OVF  = 10;
    // Debounce intervals spent holding masks across all tests
    localparam int INTERVALS = HOLD * (2*N_SINGLE + N_MULTI + 1 + N_GLITCH + 2*MAX_OVF + 4);
    // Twice the hold time covers bus traffic and alignment
    localparam int WATCHDOG = INTERVALS * TICKS * PERIOD * 2 + 1000 * PERIOD;

    logic        clk;
    logic        rstn;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        irq;
    logic [3:0]  col;
    logic [3:0]  row;
    logic [15:0] pressed;

    int unsigned edge_cnt;
    int          checks;
    int          errors;
    // Reference model state
    logic [4:0]  exp_q[$];
    logic        exp_ovf;

    keypad_top dut_i (
        .clk   (clk),
        .rstn  (rstn),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .irq   (irq),
        .col   (col),
        .row   (row)
    );

    keypad_matrix_model matrix_i (
        .row     (row),
        .pressed (pressed),
        .col     (col)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    // Edges since reset release
    // Debounce samples land on multiples of TICKS
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DLY;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Land just after the next debounce sample edge
    task automatic align_to_sample();
        next_cycle();
        while (edge_cnt % TICKS != 0) begin
            next_cycle();
        end
    endtask

    task automatic hold_intervals(input int n);
        repeat (n) align_to_sample();
    endtask

    // Classic cycle with stb held until ack
    task automatic bus_cycle(input logic write, input logic [1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        waited = 0;
        next_cycle();
        while (!ack && waited < 8) begin
            next_cycle();
            waited++;
        end
        checks++;
        if (!ack) begin
            errors++;
            $display("No bus acknowledge for address %0d by time %0t", addr, $time);
        end
        rdata = dat_r;
        next_cycle();
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        // One idle edge between cycles
        next_cycle();
    endtask

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, addr, wdata, unused_rd);
    endtask

    task automatic bus_read_check(input logic [1:0] addr, input logic [31:0] exp,
                                  input string what);
        logic [31:0] got;
        bus_cycle(1'b0, addr, 32'd0, got);
        check_value(what, got, exp);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // New presses in ascending index with chord from the whole new mask
    task automatic predict_events(input logic [15:0] old_mask, input logic [15:0] new_mask);
        logic chord;
        chord = ($countones(new_mask) > 1);
        for (int i = 0; i < 16; i++) begin
            if (new_mask[i] && !old_mask[i]) begin
                if (exp_q.size() < DEPTH) begin
                    exp_q.push_back({chord, 4'(i)});
                end else begin
                    exp_ovf = 1'b1;
                end
            end
        end
    endtask

    function automatic logic [31:0] expected_status();
        logic [31:0] s;
        s      = 32'd0;
        s[0]   = (exp_q.size() == 0);
        s[1]   = exp_ovf;
        s[7:4] = 4'(exp_q.size());
        return s;
    endfunction

    // Mask changes right after a sample so one scan completes before the next
    task automatic change_mask(input logic [15:0] new_mask);
        align_to_sample();
        predict_events(pressed, new_mask);
        pressed = new_mask;
    endtask

    task automatic drain_events();
        logic [4:0] ev;
        bus_read_check(`KP_ADDR_STATUS, expected_status(), "STATUS");
        while (exp_q.size() > 0) begin
            ev = exp_q.pop_front();
            bus_read_check(`KP_ADDR_DATA, {23'd0, 1'b1, 3'd0, ev}, "DATA event");
        end
        // Extra events from the DUT would show here
        bus_read_check(`KP_ADDR_DATA, 32'd0, "DATA when empty");
    endtask

    function automatic logic [15:0] random_multi();
        logic [15:0] m;
        m = 16'($urandom) & 16'($urandom);
        if (m == 16'd0) begin
            m = 16'd1 << ($urandom % 16);
        end
        return m;
    endfunction

    task automatic report_test(input string name, input int err_start);
        $display("%s finished with %0d errors", name, errors - err_start);
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial begin
        #(WATCHDOG);
        $display("Timeout, the run did not finish within %0d time units", WATCHDOG);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int          err_start;
        int          key;
        int          ovf_masks;
        logic [15:0] m;

        void'($urandom(SEED));
        rstn     = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 2'd0;
        dat_w    = 32'd0;
        pressed  = 16'd0;
        checks   = 0;
        errors   = 0;
        exp_ovf  = 1'b0;
        repeat (2) @(posedge clk);
        #DLY;
        rstn = 1'b1;

        // Test 1 checks reset values
        err_start = errors;
        check_value("irq after reset", 32'(irq), 32'd0);
        bus_read_check(`KP_ADDR_STATUS, 32'h1, "STATUS after reset");
        bus_read_check(`KP_ADDR_CTRL, 32'd0, "CTRL after reset");
        bus_read_check(`KP_ADDR_KEYS, 32'd0, "KEYS after reset");
        bus_read_check(`KP_ADDR_DATA, 32'd0, "DATA after reset");
        report_test("Test 1 after reset", err_start);

        // Test 2 presses one key at a time
        err_start = errors;
        bus_write(`KP_ADDR_CTRL, 32'h1);
        repeat (N_SINGLE) begin
            key = int'($urandom % 16);
            change_mask(16'd1 << key);
            hold_intervals(HOLD);
            bus_read_check(`KP_ADDR_KEYS, {16'd0, pressed}, "KEYS while held");
            drain_events();
            change_mask(16'd0);
            hold_intervals(HOLD);
            bus_read_check(`KP_ADDR_KEYS, 32'd0, "KEYS after release");
            drain_events();
        end
        report_test("Test 2 single presses", err_start);

        // Test 3 changes masks directly so some keys stay held
        err_start = errors;
        repeat (N_MULTI) begin
            change_mask(random_multi());
            hold_intervals(HOLD);
            bus_read_check(`KP_ADDR_KEYS, {16'd0, pressed}, "KEYS for multi-key mask");
            drain_events();
        end
        change_mask(16'd0);
        hold_intervals(HOLD);
        drain_events();
        report_test("Test 3 multi-key masks", err_start);

        // Test 4 places a short press mid release
        err_start = errors;
        repeat (N_GLITCH) begin
            key = int'($urandom % 16);
            align_to_sample();
            for (int i = 0; i < HOLD; i++) begin
                if (i == HOLD/2) begin
                    wait_cycles(TICKS/4);
                    pressed = 16'd1 << key;
                    wait_cycles(TICKS/8);
                    pressed = 16'd0;
                end
                align_to_sample();
            end
            bus_read_check(`KP_ADDR_KEYS, 32'd0, "KEYS after glitch");
            drain_events();
        end
        report_test("Test 4 glitches", err_start);

        // Test 5 fills past depth without reads
        err_start = errors;
        ovf_masks = 0;
        while (!exp_ovf && ovf_masks < MAX_OVF) begin
            m = random_multi();
            change_mask(m);
            hold_intervals(HOLD);
            change_mask(16'd0);
            hold_intervals(HOLD);
            ovf_masks++;
        end
        checks++;
        if (!exp_ovf) begin
            errors++;
            $display("Overflow test produced too few events to fill the FIFO");
        end
        drain_events();
        bus_write(`KP_ADDR_STATUS, 32'h2);
        exp_ovf = 1'b0;
        bus_read_check(`KP_ADDR_STATUS, expected_status(), "STATUS after overflow clear");
        report_test("Test 5 overflow", err_start);

        // Test 6 covers interrupt gating and the disabled scanner
        err_start = errors;
        bus_write(`KP_ADDR_CTRL, 32'h3);
        bus_read_check(`KP_ADDR_CTRL, 32'h3, "CTRL with irq enable");
        check_value("irq with empty FIFO", 32'(irq), 32'd0);
        key = int'($urandom % 16);
        change_mask(16'd1 << key);
        hold_intervals(HOLD);
        check_value("irq with event queued", 32'(irq), 32'd1);
        bus_write(`KP_ADDR_CTRL, 32'h1);
        wait_cycles(2);
        check_value("irq with irq enable clear", 32'(irq), 32'd0);
        bus_write(`KP_ADDR_CTRL, 32'h3);
        wait_cycles(2);
        check_value("irq after irq enable set", 32'(irq), 32'd1);
        change_mask(16'd0);
        hold_intervals(HOLD);
        drain_events();
        wait_cycles(2);
        check_value("irq after drain", 32'(irq), 32'd0);
        // Presses go unseen while the scanner is stopped
        bus_write(`KP_ADDR_CTRL, 32'h0);
        align_to_sample();
        pressed = 16'd1 << int'($urandom % 16);
        for (int i = 0; i < HOLD; i++) begin
            align_to_sample();
            check_value("row with scan disabled", 32'(row), 32'hF);
        end
        bus_read_check(`KP_ADDR_STATUS, expected_status(), "STATUS with scan disabled");
        bus_read_check(`KP_ADDR_KEYS, 32'd0, "KEYS with scan disabled");
        align_to_sample();
        pressed = 16'd0;
        report_test("Test 6 interrupt and disable", err_start);

        $display("Checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
design/keypad_pkg.sv
design/keypad_scanner.sv
design/key_debouncer.sv
design/key_event_fifo.sv
design/keypad_wb_ctrl.sv
design/keypad_top.sv
verification/keypad_matrix_model.sv
verification/tb_keypad_top.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_keypad_top
SRCS := $(wildcard design/*.sv verification/*.sv include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_keypad_top -Mdir obj_dir -o Vtb_keypad_top

# Fails when the log holds the fail message or lacks the pass message
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Checks failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All checks passed" sim.log; then \
		echo "Simulation FAILED, no result line"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log
